// File: Makefile
SRCS := $(shell grep -v '^+' ooo_issue_core.f) hdl/ooo_defines.svh

run: obj_dir/Vooo_issue_core_tb
	@out=$$(./obj_dir/Vooo_issue_core_tb); echo "$$out"; \
		echo "$$out" | grep -q "Simulation completed successfully"

# Rebuilt only when a source or the file list changes
obj_dir/Vooo_issue_core_tb: ooo_issue_core.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ns --top-module ooo_issue_core_tb \
		-f ooo_issue_core.f -o Vooo_issue_core_tb

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: bench/ooo_issue_core_tb.sv
// Self-checking testbench covering opcodes, wakeup order, dependency chains and RS full
`timescale 1ns/1ns
`include "ooo_defines.svh"

module ooo_issue_core_tb import ooo_pkg::*, isa_pkg::*; ();

    logic             clock;
    logic             reset;
    logic             dispatch_valid;
    dispatch_packet_t dispatch_in;
    logic             rs_full;
    logic             preload_valid;
    phys_reg_idx_t    preload_tag;
    data_t            preload_data;
    cdb_packet_t      cdb_out;

    logic [15:0]      lfsr = 16'd63;            // Fibonacci LFSR state
    data_t            shadow  [`PHYS_REG_SZ];   // Reference register values
    data_t            exp_val [`PHYS_REG_SZ];   // Expected result per dest tag
    logic             pending [`PHYS_REG_SZ];   // Result still owed
    cdb_packet_t      cdb_q [$];                // Broadcasts seen, oldest first

    // 0-5 opcodes, 6-7 out of order, 8-11 chain, 12-15 fill RS on tag 0, 16 held
    dispatch_packet_t stim_rows [17] = '{
        '{ALU_ADD, 4'd1, 4'd2, 4'd3},  '{ALU_SUB, 4'd1, 4'd2, 4'd4},
        '{ALU_AND, 4'd1, 4'd2, 4'd5},  '{ALU_OR,  4'd2, 4'd1, 4'd6},
        '{ALU_XOR, 4'd1, 4'd2, 4'd7},  '{ALU_SLL, 4'd1, 4'd2, 4'd8},
        '{ALU_ADD, 4'd9, 4'd3, 4'd10}, '{ALU_XOR, 4'd4, 4'd5, 4'd11},
        '{ALU_SUB, 4'd10, 4'd1, 4'd12}, '{ALU_ADD, 4'd12, 4'd2, 4'd13},
        '{ALU_SLL, 4'd13, 4'd1, 4'd14}, '{ALU_XOR, 4'd14, 4'd12, 4'd15},
        '{ALU_ADD, 4'd0, 4'd1, 4'd3},  '{ALU_SUB, 4'd2, 4'd0, 4'd4},
        '{ALU_OR,  4'd0, 4'd2, 4'd5},  '{ALU_SLL, 4'd1, 4'd0, 4'd6},
        '{ALU_XOR, 4'd1, 4'd2, 4'd7}
    };

    ooo_issue_core dut (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;      // 8 ns period
    end

    // Collect every broadcast sampled away from the active edge
    always @(negedge clock) begin
        if (!reset && cdb_out.valid === 1'b1)
            cdb_q.push_back(cdb_out);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and stimulus source
    ////////////////////////////////////////////////////////////////////////////

    function automatic data_t alu_ref(input alu_op_t op, input data_t a, input data_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];  // Low 5 bits only
            default: return '0;
        endcase
    endfunction

    // One LFSR step per bit taken
    function automatic data_t random_word();
        data_t w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            w    = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_cdb(input cdb_packet_t actual, input cdb_packet_t expected);
        if (actual !== expected)
            abort_run($sformatf(
                "ERROR t=%0t cdb_out (valid/tag/value) got %0b/%0d/%h, expected %0b/%0d/%h",
                $time, actual.valid, actual.tag, actual.value,
                expected.valid, expected.tag, expected.value));
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected)
            abort_run($sformatf("ERROR t=%0t %s got %b, expected %b",
                $time, name, actual, expected));
    endtask

    // A ready instruction broadcasts in the third cycle after its accepting edge
    task automatic check_latency();
        for (int c = 1; c <= 3; c++) begin
            @(negedge clock);
            check_flag("cdb_out.valid", cdb_out.valid, c == 3);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////////////////////////////////////////

    task automatic expect_row(input dispatch_packet_t pkt);
        exp_val[pkt.dest] = alu_ref(pkt.op, shadow[pkt.src1], shadow[pkt.src2]);
        shadow[pkt.dest]  = exp_val[pkt.dest];  // Program order view
        pending[pkt.dest] = 1'b1;
    endtask

    task automatic offer(input dispatch_packet_t pkt);
        @(posedge clock);
        dispatch_valid <= 1'b1;
        dispatch_in    <= pkt;
    endtask

    // Hold the offer until an edge with rs_full low takes it
    task automatic finish_dispatch();
        int n;
        n = 0;
        do begin
            @(negedge clock);
            n++;
            if (n > 40)
                abort_run("Timeout: rs_full stayed high, instruction was never accepted");
        end while (rs_full);
        @(posedge clock);
        dispatch_valid <= 1'b0;
    endtask

    task automatic issue_row(input int idx);
        expect_row(stim_rows[idx]);
        offer(stim_rows[idx]);
        finish_dispatch();
    endtask

    task automatic preload(input phys_reg_idx_t tag, input data_t value);
        @(posedge clock);
        preload_valid <= 1'b1;
        preload_tag   <= tag;
        preload_data  <= value;
        shadow[tag]    = value;
        @(posedge clock);
        preload_valid <= 1'b0;
    endtask

    task automatic wait_cdb(output cdb_packet_t pkt);
        int n;
        n = 0;
        while (cdb_q.size() == 0) begin
            @(negedge clock);
            n++;
            if (n > 40)
                abort_run("Timeout: no CDB broadcast arrived");
        end
        pkt = cdb_q.pop_front();
    endtask

    // Next broadcast must carry tag unless any_order accepts any owed tag
    task automatic take_result(input phys_reg_idx_t tag, input logic any_order);
        cdb_packet_t   pkt;
        cdb_packet_t   expected;
        phys_reg_idx_t want;
        wait_cdb(pkt);
        want = any_order ? pkt.tag : tag;
        if (!pending[want])
            abort_run($sformatf("CDB broadcast of tag %0d with no instruction owing it", want));
        expected = '{1'b1, want, exp_val[want]};
        check_cdb(pkt, expected);
        pending[want] = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_in    = '0;
        preload_valid  = 1'b0;
        preload_tag    = '0;
        preload_data   = '0;
        for (int i = 0; i < `PHYS_REG_SZ; i++)
            pending[i] = 1'b0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_flag("cdb_out.valid", cdb_out.valid, 1'b0);
        check_flag("rs_full", rs_full, 1'b0);

        preload(4'd1, random_word());       // Opcode sweep sources
        preload(4'd2, random_word());
        for (int i = 0; i < 6; i++) begin
            issue_row(i);
            check_latency();
            take_result(stim_rows[i].dest, 1'b0);
        end

        // Older waits on tag 9 and the younger passes it
        shadow[9] = random_word();
        issue_row(6);
        issue_row(7);
        take_result(4'd11, 1'b0);
        preload(4'd9, shadow[9]);
        take_result(4'd10, 1'b0);

        for (int i = 8; i < 12; i++)        // Chain dispatched back to back
            issue_row(i);
        for (int i = 8; i < 12; i++)
            take_result(stim_rows[i].dest, 1'b0);

        // Fill every entry behind tag 0 and hold one more
        shadow[0] = random_word();
        for (int i = 12; i < 16; i++)
            issue_row(i);
        @(negedge clock);
        check_flag("rs_full", rs_full, 1'b1);
        expect_row(stim_rows[16]);
        offer(stim_rows[16]);
        for (int c = 0; c < 5; c++) begin   // Nothing may broadcast while full
            @(negedge clock);
            check_flag("cdb_out.valid", cdb_out.valid, 1'b0);
        end
        check_flag("rs_full", rs_full, 1'b1);
        preload(4'd0, shadow[0]);
        finish_dispatch();
        for (int i = 0; i < `RS_SZ + 1; i++)
            take_result(4'd0, 1'b1);
        @(negedge clock);
        check_flag("rs_full", rs_full, 1'b0);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: hdl/alu_unit.sv
// Single-cycle ALU: reads operands of the issued op and drives the CDB
`timescale 1ns/1ns
`include "ooo_defines.svh"

module alu_unit import ooo_pkg::*, isa_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  issue_packet_t issue,
    input  data_t         read_data_1,
    input  data_t         read_data_2,
    output phys_reg_idx_t read_tag_1,
    output phys_reg_idx_t read_tag_2,
    output cdb_packet_t   cdb
);

    data_t result;

    // Regfile read is combinational, operands arrive same cycle
    assign read_tag_1 = issue.src1;
    assign read_tag_2 = issue.src2;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (issue.op)
            ALU_ADD: result = read_data_1 + read_data_2;
            ALU_SUB: result = read_data_1 - read_data_2;
            ALU_AND: result = read_data_1 & read_data_2;
            ALU_OR:  result = read_data_1 | read_data_2;
            ALU_XOR: result = read_data_1 ^ read_data_2;
            ALU_SLL: result = read_data_1 << read_data_2[4:0];
            default: result = '0;                   // Unused codes
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // CDB register
    ////////////////////////////////////////////////////////////////////////////

    // One broadcast per cycle at most, never stalls
    always_ff @(posedge clock) begin
        cdb.tag   <= issue.dest;
        cdb.value <= result;
        if (reset)
            cdb.valid <= 1'b0;
        else
            cdb.valid <= issue.valid;
    end

endmodule

// File: hdl/isa_pkg.sv
// ISA package holding the ALU opcode encoding shared by dispatch and execute
package isa_pkg;

    // ALU opcodes, 3 bit encoding
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,     // src1 + src2
        ALU_SUB = 3'd1,     // src1 - src2
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5      // Shift by low 5 bits of src2
    } alu_op_t;

    // Codes 6 and 7 unused

endpackage

// File: hdl/issue_select.sv
// Issue select that grants the lowest ready RS entry and registers it for the ALU
`timescale 1ns/1ns
`include "ooo_defines.svh"

module issue_select import ooo_pkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    input  logic       [`RS_SZ-1:0]     entry_valid,
    input  rs_packet_t [`RS_SZ-1:0]     entries,
    output logic       [`RS_SZ-1:0]     grant,      // One-hot grant frees the entry
    output issue_packet_t               issue
);

    logic [`RS_SZ-1:0] eligible;    // Valid with both operands ready
    rs_packet_t        selected;    // Granted entry after the mux

    always_comb begin
        for (int i = 0; i < `RS_SZ; i++) begin
            eligible[i] = entry_valid[i] && entries[i].src1_ready
                          && entries[i].src2_ready;
        end
    end

    assign grant = eligible & -eligible;    // Lowest index wins

    // One-hot mux
    always_comb begin
        selected = '0;
        for (int i = 0; i < `RS_SZ; i++) begin
            if (grant[i])
                selected = entries[i];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Issue register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        issue.op   <= selected.inst.op;
        issue.src1 <= selected.inst.src1;
        issue.src2 <= selected.inst.src2;
        issue.dest <= selected.inst.dest;
        if (reset)
            issue.valid <= 1'b0;
        else
            issue.valid <= |grant;      // Bubble when nothing ready
    end

endmodule

// File: hdl/ooo_defines.svh
// Sizing macros for the issue slice: RS depth, register count and widths
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Reservation station
////////////////////////////////////////////////////////////////////////////

`define RS_SZ 4             // Number of RS entries

////////////////////////////////////////////////////////////////////////////
// Physical register file
////////////////////////////////////////////////////////////////////////////

`define PHYS_REG_SZ 16      // Physical registers
`define PHYS_REG_BITS 4     // Tag width, log2 of PHYS_REG_SZ

// Operand and result width
`define DATA_WIDTH 32

`endif

// File: hdl/ooo_issue_core.sv
// Issue slice top: RS, wakeup, issue select, ALU and physical register file
`timescale 1ns/1ns
`include "ooo_defines.svh"

module ooo_issue_core import ooo_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  logic             dispatch_valid,
    input  dispatch_packet_t dispatch_in,
    output logic             rs_full,
    input  logic             preload_valid,
    input  phys_reg_idx_t    preload_tag,
    input  data_t            preload_data,
    output cdb_packet_t      cdb_out
);

    logic       [`RS_SZ-1:0] alloc;
    rs_packet_t              alloc_packet;
    logic                    dispatch_fire;
    logic       [`RS_SZ-1:0] entry_valid;
    rs_packet_t [`RS_SZ-1:0] entries;
    logic       [`RS_SZ-1:0] grant;
    issue_packet_t           issue;
    phys_reg_idx_t           read_tag_1, read_tag_2;
    data_t                   read_data_1, read_data_2;
    logic                    src1_complete, src2_complete;
    cdb_packet_t             wakeup;    // Tag broadcast seen by the RS

    // Preload also wakes waiters, CDB takes the slot if both fire
    assign wakeup.valid = cdb_out.valid || preload_valid;
    assign wakeup.tag   = cdb_out.valid ? cdb_out.tag   : preload_tag;
    assign wakeup.value = cdb_out.valid ? cdb_out.value : preload_data;

    ////////////////////////////////////////////////////////////////////////////
    // Reservation station
    ////////////////////////////////////////////////////////////////////////////

    rs_dispatch rs_dispatch_inst (.dispatch_valid, .dispatch_in, .entry_valid,
        .src1_complete, .src2_complete, .cdb(wakeup), .alloc, .alloc_packet,
        .rs_full, .dispatch_fire);

    for (genvar i = 0; i < `RS_SZ; i++) begin : g_rs
        rs_entry rs_entry_inst (.clock, .reset, .alloc(alloc[i]), .alloc_packet,
            .grant(grant[i]), .cdb(wakeup), .entry_valid(entry_valid[i]),
            .entry(entries[i]));
    end

    issue_select issue_select_inst (.clock, .reset, .entry_valid, .entries,
        .grant, .issue);

    ////////////////////////////////////////////////////////////////////////////
    // Execute and register file
    ////////////////////////////////////////////////////////////////////////////

    alu_unit alu_unit_inst (.clock, .reset, .issue, .read_data_1, .read_data_2,
        .read_tag_1, .read_tag_2, .cdb(cdb_out));

    phys_regfile phys_regfile_inst (.clock, .reset, .cdb(cdb_out), .preload_valid,
        .preload_tag, .preload_data, .dispatch_fire, .dispatch_in, .read_tag_1,
        .read_tag_2, .read_data_1, .read_data_2, .src1_complete, .src2_complete);

endmodule

// File: hdl/ooo_pkg.sv
// Core package with tag/data types and the packets passed along the issue path
`include "ooo_defines.svh"

package ooo_pkg;
    import isa_pkg::*;

    typedef logic [`PHYS_REG_BITS-1:0] phys_reg_idx_t;  // Physical tag
    typedef logic [`DATA_WIDTH-1:0]    data_t;          // Data word

    // Renamed instruction from the dispatch agent
    typedef struct packed {
        alu_op_t       op;
        phys_reg_idx_t src1;
        phys_reg_idx_t src2;
        phys_reg_idx_t dest;
    } dispatch_packet_t;

    // What an RS entry holds, instruction plus wakeup state
    typedef struct packed {
        dispatch_packet_t inst;
        logic             src1_ready;
        logic             src2_ready;
    } rs_packet_t;

    // Issued instruction headed for the ALU
    typedef struct packed {
        logic          valid;
        alu_op_t       op;
        phys_reg_idx_t src1;
        phys_reg_idx_t src2;
        phys_reg_idx_t dest;
    } issue_packet_t;

    typedef struct packed {
        logic          valid;
        phys_reg_idx_t tag;     // Completing tag
        data_t         value;   // Result
    } cdb_packet_t;

endpackage

// File: hdl/phys_regfile.sv
// Physical register file with per-register complete bits and CDB/preload writes
`timescale 1ns/1ns
`include "ooo_defines.svh"

module phys_regfile import ooo_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  cdb_packet_t      cdb,
    input  logic             preload_valid,
    input  phys_reg_idx_t    preload_tag,
    input  data_t            preload_data,
    input  logic             dispatch_fire,
    input  dispatch_packet_t dispatch_in,
    input  phys_reg_idx_t    read_tag_1,     // ALU operand ports
    input  phys_reg_idx_t    read_tag_2,
    output data_t            read_data_1,
    output data_t            read_data_2,
    output logic             src1_complete,  // Lookups for the dispatching sources
    output logic             src2_complete
);

    data_t                   data_mem [`PHYS_REG_SZ];
    logic [`PHYS_REG_SZ-1:0] complete;      // Value present in data_mem

    ////////////////////////////////////////////////////////////////////////////
    // Data array
    ////////////////////////////////////////////////////////////////////////////

    // CDB and preload never hit the same tag
    always_ff @(posedge clock) begin
        if (cdb.valid)
            data_mem[cdb.tag] <= cdb.value;
        if (preload_valid)
            data_mem[preload_tag] <= preload_data;
    end

    assign read_data_1 = data_mem[read_tag_1];
    assign read_data_2 = data_mem[read_tag_2];

    ////////////////////////////////////////////////////////////////////////////
    // Complete bits
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            complete <= '0;
        end else begin
            if (cdb.valid)
                complete[cdb.tag] <= 1'b1;
            if (preload_valid)
                complete[preload_tag] <= 1'b1;
            // New producer of dest, last so it overrides a stale completion
            if (dispatch_fire)
                complete[dispatch_in.dest] <= 1'b0;
        end
    end

    assign src1_complete = complete[dispatch_in.src1];
    assign src2_complete = complete[dispatch_in.src2];

endmodule

// File: hdl/rs_dispatch.sv
// RS dispatch logic that finds a free entry and builds its packet with initial readiness
`timescale 1ns/1ns
`include "ooo_defines.svh"

module rs_dispatch import ooo_pkg::*; (
    input  logic                  dispatch_valid,
    input  dispatch_packet_t      dispatch_in,
    input  logic [`RS_SZ-1:0]     entry_valid,
    input  logic                  src1_complete,  // Complete bit of src1 tag
    input  logic                  src2_complete,  // Complete bit of src2 tag
    input  cdb_packet_t           cdb,
    output logic [`RS_SZ-1:0]     alloc,          // One-hot lowest free entry
    output rs_packet_t            alloc_packet,
    output logic                  rs_full,
    output logic                  dispatch_fire   // Instruction accepted this cycle
);

    logic [`RS_SZ-1:0] free_mask;   // Entries open for allocation
    logic              src1_hit;    // Same-cycle broadcast of src1
    logic              src2_hit;

    ////////////////////////////////////////////////////////////////////////////
    // Allocation
    ////////////////////////////////////////////////////////////////////////////

    assign free_mask     = ~entry_valid;
    assign rs_full       = &entry_valid;                 // No slot left
    assign dispatch_fire = dispatch_valid && !rs_full;

    // Isolate lowest set bit of the free mask
    assign alloc = dispatch_fire ? (free_mask & -free_mask) : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Initial readiness
    ////////////////////////////////////////////////////////////////////////////

    // Catch a tag completing in the cycle we look it up
    // or the entry would load after the broadcast and never wake
    assign src1_hit = cdb.valid && (cdb.tag == dispatch_in.src1);
    assign src2_hit = cdb.valid && (cdb.tag == dispatch_in.src2);

    always_comb begin
        alloc_packet.inst       = dispatch_in;
        alloc_packet.src1_ready = src1_complete || src1_hit;
        alloc_packet.src2_ready = src2_complete || src2_hit;
    end

endmodule

// File: hdl/rs_entry.sv
// Single reservation station slot with CDB tag match wakeup
`timescale 1ns/1ns
`include "ooo_defines.svh"

module rs_entry import ooo_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        alloc,          // Load this slot
    input  rs_packet_t  alloc_packet,
    input  logic        grant,          // Issue select took this slot
    input  cdb_packet_t cdb,
    output logic        entry_valid,
    output rs_packet_t  entry
);

    logic src1_hit;     // Broadcast tag matches src1
    logic src2_hit;     // Broadcast tag matches src2

    assign src1_hit = cdb.valid && (cdb.tag == entry.inst.src1);
    assign src2_hit = cdb.valid && (cdb.tag == entry.inst.src2);

    ////////////////////////////////////////////////////////////////////////////
    // Occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= 1'b0;
        end else if (alloc) begin
            entry_valid <= 1'b1;
        end else if (grant) begin
            entry_valid <= 1'b0;    // Freed on issue
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Payload and wakeup
    ////////////////////////////////////////////////////////////////////////////

    // Ready flags only meaningful while valid
    always_ff @(posedge clock) begin
        if (alloc) begin
            entry <= alloc_packet;
        end else begin
            if (src1_hit)
                entry.src1_ready <= 1'b1;
            if (src2_hit)
                entry.src2_ready <= 1'b1;
        end
    end

endmodule

// File: ooo_issue_core.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/ooo_pkg.sv
hdl/rs_dispatch.sv
hdl/rs_entry.sv
hdl/issue_select.sv
hdl/phys_regfile.sv
hdl/alu_unit.sv
hdl/ooo_issue_core.sv
bench/ooo_issue_core_tb.sv
